// File: warp_pkg.sv
`default_nettype none

package warp_pkg;

    // ##########################################################
    // Sizes
    // ##########################################################

    // Warps per compute unit
    localparam int NUM_WARPS = 4;
    localparam int WID_WIDTH = 2;
    // Threads per warp, one mask bit each
    localparam int WARP_WIDTH = 4;
    // Byte address of an instruction
    localparam int PC_WIDTH = 16;
    localparam int INSTR_WIDTH = 32;

    // Fetch buffer geometry
    localparam int BUF_DEPTH = 4;
    localparam int BUF_CNT_WIDTH = 3;
    localparam int BUF_PTR_WIDTH = 2;

    // ##########################################################
    // Instruction encoding
    // ##########################################################

    localparam logic [7:0] OPC_ALU  = 8'h10;
    localparam logic [7:0] OPC_JUMP = 8'h20;
    localparam logic [7:0] OPC_EXIT = 8'h3f;

    // One word, two views selected by the opcode
    typedef union packed {
        struct packed {
            logic [7:0] opcode;
            logic [7:0] rd;
            logic [7:0] rs1;
            logic [7:0] imm;
        } alu_fmt;
        struct packed {
            logic [7:0]         opcode;
            // Jump distance in instructions, not bytes
            logic signed [23:0] offset;
        } ctrl_fmt;
    } instr_t;

endpackage

`default_nettype wire

// File: warp_state_table.sv
`timescale 1ns/1ps
`default_nettype none

module warp_state_table (
    input  wire logic                                                 clk_i,
    input  wire logic                                                 rst_n_i,
    input  wire logic                                                 start_i,
    input  wire logic [warp_pkg::NUM_WARPS-1:0]                       warp_selected_i,
    input  wire logic                                                 instruction_decoded_i,
    input  wire logic                                                 decode_stop_warp_i,
    input  wire logic [warp_pkg::WID_WIDTH-1:0]                       decode_wid_i,
    input  wire logic [warp_pkg::PC_WIDTH-1:0]                        decode_next_pc_i,
    output logic      [warp_pkg::NUM_WARPS-1:0]                       warp_active_o,
    output logic      [warp_pkg::NUM_WARPS-1:0]                       warp_stopped_o,
    output logic      [warp_pkg::NUM_WARPS-1:0]                       warp_ready_o,
    output logic      [warp_pkg::NUM_WARPS-1:0][warp_pkg::PC_WIDTH-1:0]   warp_pc_o,
    output logic      [warp_pkg::NUM_WARPS-1:0][warp_pkg::WARP_WIDTH-1:0] warp_act_mask_o
);
    import warp_pkg::*;

    // Per-warp record, split into flat arrays
    logic [NUM_WARPS-1:0]                 active_q, active_d;
    logic [NUM_WARPS-1:0]                 stopped_q, stopped_d;
    logic [NUM_WARPS-1:0]                 ready_q, ready_d;
    logic [NUM_WARPS-1:0][PC_WIDTH-1:0]   pc_q, pc_d;
    logic [NUM_WARPS-1:0][WARP_WIDTH-1:0] mask_q, mask_d;

    // ##########################################################
    // Next state
    // ##########################################################

    always_comb begin : next_state
        active_d  = active_q;
        stopped_d = stopped_q;
        ready_d   = ready_q;
        pc_d      = pc_q;
        mask_d    = mask_q;

        // Start wakes every warp with one thread at its own index
        if (start_i) begin
            for (int i = 0; i < NUM_WARPS; i++) begin
                active_d[i] = 1'b1;
                ready_d[i]  = 1'b1;
                mask_d[i]   = WARP_WIDTH'(1) << i;
            end
        end

        // Decode report writes back the PC and releases the warp
        if (instruction_decoded_i) begin
            pc_d[decode_wid_i]    = decode_next_pc_i;
            ready_d[decode_wid_i] = 1'b1;
            // Exit retires the warp for good
            if (decode_stop_warp_i) begin
                stopped_d[decode_wid_i] = 1'b1;
                active_d[decode_wid_i]  = 1'b0;
                ready_d[decode_wid_i]   = 1'b0;
            end
        end

        // Selected warp waits until its instruction is decoded
        for (int i = 0; i < NUM_WARPS; i++) begin
            if (warp_selected_i[i]) begin
                ready_d[i] = 1'b0;
            end
        end
    end

    // ##########################################################
    // State registers
    // ##########################################################

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            active_q  <= '0;
            stopped_q <= '0;
            ready_q   <= '0;
            pc_q      <= '0;
            mask_q    <= '0;
        end else begin
            active_q  <= active_d;
            stopped_q <= stopped_d;
            ready_q   <= ready_d;
            pc_q      <= pc_d;
            mask_q    <= mask_d;
        end
    end

    // Ready only if active with at least one live thread
    for (genvar i = 0; i < NUM_WARPS; i++) begin : gen_ready
        assign warp_ready_o[i] = ready_q[i] && active_q[i] && (|mask_q[i]);
    end

    assign warp_active_o   = active_q;
    assign warp_stopped_o  = stopped_q;
    assign warp_pc_o       = pc_q;
    assign warp_act_mask_o = mask_q;

endmodule

`default_nettype wire

// File: warp_scheduler.sv
`timescale 1ns/1ps
`default_nettype none

module warp_scheduler (
    input  wire logic                                                 clk_i,
    input  wire logic                                                 rst_n_i,
    input  wire logic [warp_pkg::NUM_WARPS-1:0]                       warp_ready_i,
    input  wire logic [warp_pkg::NUM_WARPS-1:0][warp_pkg::PC_WIDTH-1:0]   warp_pc_i,
    input  wire logic [warp_pkg::NUM_WARPS-1:0][warp_pkg::WARP_WIDTH-1:0] warp_act_mask_i,
    input  wire logic [warp_pkg::BUF_CNT_WIDTH-1:0]                   buf_count_i,
    input  wire logic [warp_pkg::INSTR_WIDTH-1:0]                     imem_rdata_i,
    output logic      [warp_pkg::NUM_WARPS-1:0]                       warp_selected_o,
    output logic                                                      imem_req_o,
    output logic      [warp_pkg::PC_WIDTH-1:0]                        imem_addr_o,
    output logic                                                      push_o,
    output logic      [warp_pkg::WID_WIDTH-1:0]                       push_wid_o,
    output logic      [warp_pkg::PC_WIDTH-1:0]                        push_pc_o,
    output logic      [warp_pkg::WARP_WIDTH-1:0]                      push_mask_o,
    output logic      [warp_pkg::INSTR_WIDTH-1:0]                     push_instr_o
);
    import warp_pkg::*;

    // Last warp chosen, search starts just after it
    logic [WID_WIDTH-1:0]     rr_ptr_q;
    logic                     sel_found;
    logic [WID_WIDTH-1:0]     sel_wid;
    // Buffer slots already claimed, including the fetch in flight
    logic [BUF_CNT_WIDTH-1:0] pending;
    logic                     can_select;
    logic                     fire;
    // Outstanding fetch
    logic                     fetch_valid_q;
    logic [WID_WIDTH-1:0]     fetch_wid_q;
    logic [PC_WIDTH-1:0]      fetch_pc_q;
    logic [WARP_WIDTH-1:0]    fetch_mask_q;

    // ##########################################################
    // Round-robin pick
    // ##########################################################

    always_comb begin : rr_pick
        logic [WID_WIDTH-1:0] idx;
        sel_found = 1'b0;
        sel_wid   = rr_ptr_q;
        for (int i = 1; i <= NUM_WARPS; i++) begin
            idx = rr_ptr_q + WID_WIDTH'(i);
            if (!sel_found && warp_ready_i[idx]) begin
                sel_found = 1'b1;
                sel_wid   = idx;
            end
        end
    end

    // Throttle so a push never meets a full buffer
    assign pending    = buf_count_i + BUF_CNT_WIDTH'(fetch_valid_q);
    assign can_select = pending < BUF_CNT_WIDTH'(BUF_DEPTH);
    assign fire       = sel_found && can_select;

    assign warp_selected_o = fire ? (NUM_WARPS'(1) << sel_wid) : '0;
    assign imem_req_o      = fire;
    assign imem_addr_o     = warp_pc_i[sel_wid];

    // ##########################################################
    // Fetch tracking
    // ##########################################################

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rr_ptr_q      <= WID_WIDTH'(NUM_WARPS - 1);
            fetch_valid_q <= 1'b0;
        end else begin
            fetch_valid_q <= fire;
            if (fire) begin
                rr_ptr_q <= sel_wid;
            end
        end
    end

    // Tag of the request, held until the read data returns
    always_ff @(posedge clk_i) begin
        if (fire) begin
            fetch_wid_q  <= sel_wid;
            fetch_pc_q   <= warp_pc_i[sel_wid];
            fetch_mask_q <= warp_act_mask_i[sel_wid];
        end
    end

    // Memory answers one cycle later, push straight through
    assign push_o       = fetch_valid_q;
    assign push_wid_o   = fetch_wid_q;
    assign push_pc_o    = fetch_pc_q;
    assign push_mask_o  = fetch_mask_q;
    assign push_instr_o = imem_rdata_i;

endmodule

`default_nettype wire

// File: fetch_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_buffer (
    input  wire logic                               clk_i,
    input  wire logic                               rst_n_i,
    input  wire logic                               push_i,
    input  wire logic [warp_pkg::WID_WIDTH-1:0]     push_wid_i,
    input  wire logic [warp_pkg::PC_WIDTH-1:0]      push_pc_i,
    input  wire logic [warp_pkg::WARP_WIDTH-1:0]    push_mask_i,
    input  wire logic [warp_pkg::INSTR_WIDTH-1:0]   push_instr_i,
    input  wire logic                               pop_i,
    output logic                                    empty_o,
    output logic      [warp_pkg::BUF_CNT_WIDTH-1:0] count_o,
    output logic      [warp_pkg::WID_WIDTH-1:0]     head_wid_o,
    output logic      [warp_pkg::PC_WIDTH-1:0]      head_pc_o,
    output logic      [warp_pkg::WARP_WIDTH-1:0]    head_mask_o,
    output logic      [warp_pkg::INSTR_WIDTH-1:0]   head_instr_o
);
    import warp_pkg::*;

    // Entry storage, one array per field
    logic [WID_WIDTH-1:0]     wid_mem   [BUF_DEPTH];
    logic [PC_WIDTH-1:0]      pc_mem    [BUF_DEPTH];
    logic [WARP_WIDTH-1:0]    mask_mem  [BUF_DEPTH];
    logic [INSTR_WIDTH-1:0]   instr_mem [BUF_DEPTH];

    logic [BUF_PTR_WIDTH-1:0] wr_ptr_q;
    logic [BUF_PTR_WIDTH-1:0] rd_ptr_q;
    logic [BUF_CNT_WIDTH-1:0] count_q;

    // Pointers wrap naturally at the power-of-two depth
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop_i) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            // Simultaneous push and pop cancel out
            if (push_i && !pop_i) begin
                count_q <= count_q + 1'b1;
            end else if (pop_i && !push_i) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            wid_mem[wr_ptr_q]   <= push_wid_i;
            pc_mem[wr_ptr_q]    <= push_pc_i;
            mask_mem[wr_ptr_q]  <= push_mask_i;
            instr_mem[wr_ptr_q] <= push_instr_i;
        end
    end

    assign empty_o      = (count_q == '0);
    assign count_o      = count_q;
    // Head is the oldest entry
    assign head_wid_o   = wid_mem[rd_ptr_q];
    assign head_pc_o    = pc_mem[rd_ptr_q];
    assign head_mask_o  = mask_mem[rd_ptr_q];
    assign head_instr_o = instr_mem[rd_ptr_q];

endmodule

`default_nettype wire

// File: warp_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module warp_decoder (
    input  wire logic                             clk_i,
    input  wire logic                             rst_n_i,
    input  wire logic                             empty_i,
    input  wire logic [warp_pkg::WID_WIDTH-1:0]   head_wid_i,
    input  wire logic [warp_pkg::PC_WIDTH-1:0]    head_pc_i,
    input  wire logic [warp_pkg::WARP_WIDTH-1:0]  head_mask_i,
    input  wire logic [warp_pkg::INSTR_WIDTH-1:0] head_instr_i,
    output logic                                  pop_o,
    output logic                                  instruction_decoded_o,
    output logic      [warp_pkg::WID_WIDTH-1:0]   decode_wid_o,
    output logic      [warp_pkg::PC_WIDTH-1:0]    decode_next_pc_o,
    output logic                                  decode_stop_warp_o,
    output logic                                  issue_valid_o,
    output logic      [warp_pkg::WID_WIDTH-1:0]   issue_wid_o,
    output logic      [warp_pkg::PC_WIDTH-1:0]    issue_pc_o,
    output logic      [warp_pkg::WARP_WIDTH-1:0]  issue_act_mask_o,
    output logic      [7:0]                       issue_opcode_o,
    output logic      [warp_pkg::INSTR_WIDTH-1:0] issue_instr_o
);
    import warp_pkg::*;

    logic [7:0]          opcode;
    logic [PC_WIDTH-1:0] next_pc;
    logic                stop;

    // Consume whenever something is waiting
    assign pop_o = !empty_i;

    // ##########################################################
    // Decode
    // ##########################################################

    always_comb begin : decode
        instr_t instr;
        instr   = head_instr_i;
        // Opcode sits in the same byte in both views
        opcode  = instr.alu_fmt.opcode;
        next_pc = head_pc_i + PC_WIDTH'(4);
        stop    = 1'b0;
        case (opcode)
            OPC_JUMP: begin
                // Instruction offset to bytes, wraps in the PC width
                next_pc = head_pc_i + {instr.ctrl_fmt.offset[PC_WIDTH-3:0], 2'b00};
            end
            OPC_EXIT: begin
                stop = 1'b1;
            end
            // ALU and unknown opcodes fall through
            default: begin
                next_pc = head_pc_i + PC_WIDTH'(4);
            end
        endcase
    end

    // ##########################################################
    // Output registers
    // ##########################################################

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            instruction_decoded_o <= 1'b0;
            issue_valid_o         <= 1'b0;
            decode_stop_warp_o    <= 1'b0;
        end else begin
            instruction_decoded_o <= pop_o;
            issue_valid_o         <= pop_o;
            if (pop_o) begin
                decode_stop_warp_o <= stop;
            end
        end
    end

    // Report and issue record move together
    always_ff @(posedge clk_i) begin
        if (pop_o) begin
            decode_wid_o     <= head_wid_i;
            decode_next_pc_o <= next_pc;
            issue_wid_o      <= head_wid_i;
            issue_pc_o       <= head_pc_i;
            issue_act_mask_o <= head_mask_i;
            issue_opcode_o   <= opcode;
            issue_instr_o    <= head_instr_i;
        end
    end

endmodule

`default_nettype wire

// File: warp_frontend.sv
`timescale 1ns/1ps
`default_nettype none

module warp_frontend (
    input  wire logic                             clk_i,
    input  wire logic                             rst_n_i,
    input  wire logic                             start_i,
    input  wire logic [warp_pkg::INSTR_WIDTH-1:0] imem_rdata_i,
    output logic                                  imem_req_o,
    output logic      [warp_pkg::PC_WIDTH-1:0]    imem_addr_o,
    output logic      [warp_pkg::NUM_WARPS-1:0]   warp_active_o,
    output logic      [warp_pkg::NUM_WARPS-1:0]   warp_stopped_o,
    output logic                                  issue_valid_o,
    output logic      [warp_pkg::WID_WIDTH-1:0]   issue_wid_o,
    output logic      [warp_pkg::PC_WIDTH-1:0]    issue_pc_o,
    output logic      [warp_pkg::WARP_WIDTH-1:0]  issue_act_mask_o,
    output logic      [7:0]                       issue_opcode_o,
    output logic      [warp_pkg::INSTR_WIDTH-1:0] issue_instr_o
);
    import warp_pkg::*;

    // State table and scheduler
    logic [NUM_WARPS-1:0]                 warp_ready;
    logic [NUM_WARPS-1:0][PC_WIDTH-1:0]   warp_pc;
    logic [NUM_WARPS-1:0][WARP_WIDTH-1:0] warp_act_mask;
    logic [NUM_WARPS-1:0]                 warp_selected;
    // Scheduler into buffer
    logic                                 push;
    logic [WID_WIDTH-1:0]                 push_wid;
    logic [PC_WIDTH-1:0]                  push_pc;
    logic [WARP_WIDTH-1:0]                push_mask;
    logic [INSTR_WIDTH-1:0]               push_instr;
    logic [BUF_CNT_WIDTH-1:0]             buf_count;
    // Buffer into decoder
    logic                                 empty;
    logic                                 pop;
    logic [WID_WIDTH-1:0]                 head_wid;
    logic [PC_WIDTH-1:0]                  head_pc;
    logic [WARP_WIDTH-1:0]                head_mask;
    logic [INSTR_WIDTH-1:0]               head_instr;
    // Decode report back to the state table
    logic                                 instruction_decoded;
    logic [WID_WIDTH-1:0]                 decode_wid;
    logic [PC_WIDTH-1:0]                  decode_next_pc;
    logic                                 decode_stop_warp;

    warp_state_table i_state_table (
        .clk_i                 (clk_i),
        .rst_n_i               (rst_n_i),
        .start_i               (start_i),
        .warp_selected_i       (warp_selected),
        .instruction_decoded_i (instruction_decoded),
        .decode_stop_warp_i    (decode_stop_warp),
        .decode_wid_i          (decode_wid),
        .decode_next_pc_i      (decode_next_pc),
        .warp_active_o         (warp_active_o),
        .warp_stopped_o        (warp_stopped_o),
        .warp_ready_o          (warp_ready),
        .warp_pc_o             (warp_pc),
        .warp_act_mask_o       (warp_act_mask)
    );

    warp_scheduler i_scheduler (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .warp_ready_i    (warp_ready),
        .warp_pc_i       (warp_pc),
        .warp_act_mask_i (warp_act_mask),
        .buf_count_i     (buf_count),
        .imem_rdata_i    (imem_rdata_i),
        .warp_selected_o (warp_selected),
        .imem_req_o      (imem_req_o),
        .imem_addr_o     (imem_addr_o),
        .push_o          (push),
        .push_wid_o      (push_wid),
        .push_pc_o       (push_pc),
        .push_mask_o     (push_mask),
        .push_instr_o    (push_instr)
    );

    fetch_buffer i_fetch_buffer (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .push_i       (push),
        .push_wid_i   (push_wid),
        .push_pc_i    (push_pc),
        .push_mask_i  (push_mask),
        .push_instr_i (push_instr),
        .pop_i        (pop),
        .empty_o      (empty),
        .count_o      (buf_count),
        .head_wid_o   (head_wid),
        .head_pc_o    (head_pc),
        .head_mask_o  (head_mask),
        .head_instr_o (head_instr)
    );

    warp_decoder i_decoder (
        .clk_i                 (clk_i),
        .rst_n_i               (rst_n_i),
        .empty_i               (empty),
        .head_wid_i            (head_wid),
        .head_pc_i             (head_pc),
        .head_mask_i           (head_mask),
        .head_instr_i          (head_instr),
        .pop_o                 (pop),
        .instruction_decoded_o (instruction_decoded),
        .decode_wid_o          (decode_wid),
        .decode_next_pc_o      (decode_next_pc),
        .decode_stop_warp_o    (decode_stop_warp),
        .issue_valid_o         (issue_valid_o),
        .issue_wid_o           (issue_wid_o),
        .issue_pc_o            (issue_pc_o),
        .issue_act_mask_o      (issue_act_mask_o),
        .issue_opcode_o        (issue_opcode_o),
        .issue_instr_o         (issue_instr_o)
    );

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);
    // 20 ns period
    initial clk_o = 1'b0;
    always #10 clk_o = ~clk_o;

    // Reset held low for the first 4 rising edges
    initial begin
        rst_n_o = 1'b0;
        repeat (4) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

`default_nettype wire

// File: tb_warp_frontend.sv
`timescale 1ns/1ps
`default_nettype none

module tb_warp_frontend;
    import warp_pkg::*;

    localparam int MEM_WORDS      = 256;
    // Words from here on are all exit
    localparam int EXIT_ZONE      = 200;
    localparam int TIMEOUT_CYCLES = 20000;

    logic                   clk_i;
    logic                   rst_n_i;
    logic                   start_i;
    logic [INSTR_WIDTH-1:0] imem_rdata_i;
    logic                   imem_req_o;
    logic [PC_WIDTH-1:0]    imem_addr_o;
    logic [NUM_WARPS-1:0]   warp_active_o;
    logic [NUM_WARPS-1:0]   warp_stopped_o;
    logic                   issue_valid_o;
    logic [WID_WIDTH-1:0]   issue_wid_o;
    logic [PC_WIDTH-1:0]    issue_pc_o;
    logic [WARP_WIDTH-1:0]  issue_act_mask_o;
    logic [7:0]             issue_opcode_o;
    logic [INSTR_WIDTH-1:0] issue_instr_o;

    logic [INSTR_WIDTH-1:0] imem [MEM_WORDS];
    integer                 seed = 32'hbda1_e251;
    int                     value_errors = 0;
    int                     other_errors = 0;
    // Scoreboard holds one expected PC and issue count per warp
    logic [PC_WIDTH-1:0]    exp_pc [NUM_WARPS];
    int                     issue_count [NUM_WARPS];
    logic [NUM_WARPS-1:0]   exited = '0;
    int                     ref_len;
    int                     cycles;

    tb_clock_gen i_clock_gen (.clk_o(clk_i), .rst_n_o(rst_n_i));

    warp_frontend i_dut (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .start_i          (start_i),
        .imem_rdata_i     (imem_rdata_i),
        .imem_req_o       (imem_req_o),
        .imem_addr_o      (imem_addr_o),
        .warp_active_o    (warp_active_o),
        .warp_stopped_o   (warp_stopped_o),
        .issue_valid_o    (issue_valid_o),
        .issue_wid_o      (issue_wid_o),
        .issue_pc_o       (issue_pc_o),
        .issue_act_mask_o (issue_act_mask_o),
        .issue_opcode_o   (issue_opcode_o),
        .issue_instr_o    (issue_instr_o)
    );

    // ##########################################################
    // Reference model
    // ##########################################################

    // Bit PC_WIDTH set means the warp stops, else the low bits are the next PC
    function automatic logic [PC_WIDTH:0] ref_next(input logic [PC_WIDTH-1:0] pc,
                                                   input logic [INSTR_WIDTH-1:0] words [MEM_WORDS]);
        logic [INSTR_WIDTH-1:0] w;
        int                     off;
        w   = words[pc[9:2]];
        off = int'($signed(w[23:0]));
        if (w[31:24] == OPC_EXIT) begin
            return {1'b1, pc};
        end
        // Offset counts instructions of 4 bytes
        if (w[31:24] == OPC_JUMP) begin
            return {1'b0, PC_WIDTH'(int'(pc) + off * 4)};
        end
        return {1'b0, PC_WIDTH'(pc + 16'd4)};
    endfunction

    // About 60% ALU, 30% short forward jump, 10% exit
    task automatic fill_imem();
        logic [31:0] kind;
        logic [31:0] field;
        for (int a = 0; a < MEM_WORDS; a++) begin
            kind  = $random(seed);
            field = $random(seed);
            if (a >= EXIT_ZONE) imem[a] = {OPC_EXIT, 16'h0000, 8'(a)};
            else if (kind % 10 < 6) imem[a] = {OPC_ALU, field[23:0]};
            else if (kind % 10 < 9) imem[a] = {OPC_JUMP, 24'(1 + field % 3)};
            else imem[a] = {OPC_EXIT, field[23:0]};
        end
    endtask

    // Every warp starts at PC 0, so all share one trace
    function automatic int trace_length();
        logic [PC_WIDTH:0]   nxt;
        logic [PC_WIDTH-1:0] pc;
        int                  n;
        pc = '0;
        n  = 0;
        while (n < MEM_WORDS * 2) begin
            n++;
            nxt = ref_next(pc, imem);
            if (nxt[PC_WIDTH]) break;
            pc = nxt[PC_WIDTH-1:0];
        end
        return n;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("FAILED t=%0t %s expected %h actual %h", $time, name, exp, act);
        value_errors++;
    endtask

    function automatic logic traces_complete();
        logic done;
        done = (warp_stopped_o == '1);
        for (int i = 0; i < NUM_WARPS; i++) begin
            if (issue_count[i] < ref_len) done = 1'b0;
        end
        return done;
    endfunction

    // Instruction memory with one cycle of read latency
    always @(posedge clk_i) begin
        if (imem_req_o) begin
            imem_rdata_i <= imem[imem_addr_o[9:2]];
        end
    end

    // ##########################################################
    // Comparing process
    // ##########################################################

    always @(negedge clk_i) begin : compare
        logic [PC_WIDTH:0]      nxt;
        logic [WID_WIDTH-1:0]   w;
        logic [INSTR_WIDTH-1:0] exp_word;
        if (rst_n_i) begin
            // Retired warps stay stopped and inactive
            for (int i = 0; i < NUM_WARPS; i++) begin
                if (exited[i]) begin
                    assert (warp_stopped_o[i] && !warp_active_o[i]) else begin
                        $display("t=%0t warp %0d not stopped and inactive after exit", $time, i);
                        other_errors++;
                    end
                end
            end
            if (issue_valid_o) begin
                w        = issue_wid_o;
                exp_word = imem[exp_pc[w][9:2]];
                assert (!exited[w]) else begin
                    $display("t=%0t warp %0d issued after its exit", $time, w);
                    other_errors++;
                end
                assert (issue_pc_o == exp_pc[w])
                    else report_mismatch("issue_pc_o", exp_pc[w], issue_pc_o);
                assert (issue_act_mask_o == WARP_WIDTH'(1) << w)
                    else report_mismatch("issue_act_mask_o", WARP_WIDTH'(1) << w, issue_act_mask_o);
                assert (issue_instr_o == exp_word)
                    else report_mismatch("issue_instr_o", exp_word, issue_instr_o);
                // Opcode is the top byte of the stored word
                assert (issue_opcode_o == exp_word[31:24])
                    else report_mismatch("issue_opcode_o", exp_word[31:24], issue_opcode_o);
                // Step the expected trace of this warp
                nxt = ref_next(exp_pc[w], imem);
                issue_count[w]++;
                if (nxt[PC_WIDTH]) exited[w] = 1'b1;
                else exp_pc[w] = nxt[PC_WIDTH-1:0];
            end
        end
    end

    // ##########################################################
    // Stimulus
    // ##########################################################

    initial begin
        start_i      = 1'b0;
        imem_rdata_i = '0;
        for (int i = 0; i < NUM_WARPS; i++) begin
            exp_pc[i]      = '0;
            issue_count[i] = 0;
        end
        fill_imem();
        ref_len = trace_length();

        cycles = 0;
        while (!rst_n_i && cycles < 100) begin
            @(posedge clk_i);
            cycles++;
        end
        if (!rst_n_i) begin
            $display("t=%0t reset never released", $time);
            other_errors++;
        end

        // Idle until started
        repeat (10) begin
            @(negedge clk_i);
            assert (warp_active_o == '0) else report_mismatch("warp_active_o", 0, warp_active_o);
            assert (warp_stopped_o == '0) else report_mismatch("warp_stopped_o", 0, warp_stopped_o);
            assert (!imem_req_o) else report_mismatch("imem_req_o", 0, imem_req_o);
            assert (!issue_valid_o) else report_mismatch("issue_valid_o", 0, issue_valid_o);
        end

        @(posedge clk_i);
        start_i <= 1'b1;
        @(posedge clk_i);
        start_i <= 1'b0;
        @(negedge clk_i);
        assert (warp_active_o == '1) else report_mismatch("warp_active_o", 4'hf, warp_active_o);

        cycles = 0;
        while (!traces_complete() && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk_i);
            cycles++;
        end
        if (!traces_complete()) begin
            $display("t=%0t timeout waiting for all warps to stop", $time);
            other_errors++;
        end

        // Nothing more may issue once every warp is done
        repeat (20) @(posedge clk_i);
        for (int i = 0; i < NUM_WARPS; i++) begin
            assert (issue_count[i] == ref_len)
                else report_mismatch($sformatf("issue_count[%0d]", i), ref_len, issue_count[i]);
        end

        $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: warp_frontend.f
warp_pkg.sv
warp_state_table.sv
warp_scheduler.sv
fetch_buffer.sv
warp_decoder.sv
warp_frontend.sv
tb_clock_gen.sv
tb_warp_frontend.sv
